//--- common/rob_pkg.sv
// shared widths, register index types and the dispatch / commit entry structs
// of the reorder buffer

package rob_pkg;

    // ==================================================================
    // architectural sizes
    // ==================================================================

    // integer register file seen by software
    parameter int unsigned ARCH_REGS = 32;

    // renamed register pool
    parameter int unsigned PHYS_REGS = 64;

    // data path width
    parameter int unsigned XLEN = 32;

    // ==================================================================
    // index and data types
    // ==================================================================

    // architectural destination index
    typedef logic [$clog2(ARCH_REGS)-1:0] arch_reg_t;

    // physical register tag
    typedef logic [$clog2(PHYS_REGS)-1:0] phys_reg_t;

    // result value from writeback, carried to commit
    typedef logic [XLEN-1:0] xlen_word_t;

    // ==================================================================
    // entry payloads
    // ==================================================================

    // fields written by dispatch into one entry, 18 bits
    typedef struct packed {
        logic      rd_wen;
        arch_reg_t rd_arch;
        phys_reg_t new_prf;
        // mapping replaced by this instruction, freed at commit
        phys_reg_t old_prf;
    } disp_entry_t;

    // what commit hands back to the core, 50 bits
    typedef struct packed {
        disp_entry_t disp;
        xlen_word_t  value;
    } commit_entry_t;

endpackage

//--- rob/rob_alloc.sv
// tail pointer of the reorder buffer, allocation decision for dispatch
// and tail rollback on a branch mispredict
`timescale 1ns/1ps

module rob_alloc #(
    parameter int unsigned DEPTH = 16
) (
    input  logic                     clock,
    input  logic                     reset,

    // dispatch request and table status
    input  logic                     disp_valid_i,
    input  logic                     full_i,

    // branch recovery
    input  logic                     mispredict_i,
    input  logic [$clog2(DEPTH)-1:0] mispredict_rob_idx_i,

    // to the entry table and the dispatcher
    output logic                     alloc_en_o,
    output logic [$clog2(DEPTH)-1:0] tail_idx_o,
    output logic                     disp_ready_o
);

    localparam int unsigned IDX_W = $clog2(DEPTH);

    // next free slot
    logic [IDX_W-1:0] tail_q;

    // one past the mispredicted entry, wraps with the index width
    logic [IDX_W-1:0] rollback_idx;

    assign rollback_idx = mispredict_rob_idx_i + IDX_W'(1);

    // space is left as long as the table is not full
    assign disp_ready_o = ~full_i;

    // no allocation in a squash cycle, the tail is being rewritten
    assign alloc_en_o = disp_valid_i & ~full_i & ~mispredict_i;

    // dispatcher sees the slot it gets in this same cycle
    assign tail_idx_o = tail_q;

    // ==================================================================
    // tail pointer
    // ==================================================================

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            tail_q <= '0;
        end else if (mispredict_i) begin
            // drop everything younger than the branch
            tail_q <= rollback_idx;
        end else if (alloc_en_o) begin
            // DEPTH is a power of two, so the add wraps by itself
            tail_q <= tail_q + IDX_W'(1);
        end
    end

endmodule

//--- rob/rob_retire.sv
// head pointer of the reorder buffer, in-order retire decision
// and the registered commit outputs
`timescale 1ns/1ps

module rob_retire #(
    parameter int unsigned DEPTH = 16
) (
    input  logic                     clock,
    input  logic                     reset,

    // state of the oldest entry, from the entry table
    input  logic                     empty_i,
    input  logic                     head_valid_i,
    input  logic                     head_ready_i,
    input  rob_pkg::commit_entry_t   head_entry_i,

    // branch recovery, blocks commit for the cycle
    input  logic                     mispredict_i,

    // to the entry table
    output logic                     retire_en_o,
    output logic [$clog2(DEPTH)-1:0] head_idx_o,

    // to the core
    output logic                     commit_valid_o,
    output rob_pkg::commit_entry_t   commit_entry_o
);

    localparam int unsigned IDX_W = $clog2(DEPTH);

    // oldest entry still in flight
    logic [IDX_W-1:0] head_q;

    // one-cycle commit strobe
    logic             commit_valid_q;

    // ==================================================================
    // retire decision
    // ==================================================================

    // empty_i guards against a stale slot after the table wrapped
    // valid and ready must both be set on the head entry
    // a squash cycle never retires
    assign retire_en_o = ~empty_i & head_valid_i & head_ready_i & ~mispredict_i;

    assign head_idx_o = head_q;

    // ==================================================================
    // head pointer and commit strobe
    // ==================================================================

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            head_q         <= '0;
            commit_valid_q <= 1'b0;
        end else begin
            // pulse for exactly one cycle per retired entry
            commit_valid_q <= retire_en_o;
            if (retire_en_o) begin
                // wraps at DEPTH through the index width
                head_q <= head_q + IDX_W'(1);
            end
        end
    end

    // commit payload, captured only when an entry leaves
    always_ff @(posedge clock) begin
        if (retire_en_o) begin
            commit_entry_o <= head_entry_i;
        end
    end

    assign commit_valid_o = commit_valid_q;

endmodule

//--- rob/rob_entry_table.sv
// entry storage of the reorder buffer with occupancy count,
// writeback merge and the squash mask for mispredict recovery
`timescale 1ns/1ps

module rob_entry_table #(
    parameter int unsigned DEPTH    = 16,
    parameter int unsigned WB_WIDTH = 2
) (
    input  logic                                    clock,
    input  logic                                    reset,
    input  logic                                    mispredict_i,
    input  logic [$clog2(DEPTH)-1:0]                mispredict_rob_idx_i,

    // from allocation and retire
    input  logic                                    alloc_en_i,
    input  logic [$clog2(DEPTH)-1:0]                tail_idx_i,
    input  rob_pkg::disp_entry_t                    disp_entry_i,
    input  logic                                    retire_en_i,
    input  logic [$clog2(DEPTH)-1:0]                head_idx_i,

    // writeback ports
    input  logic [WB_WIDTH-1:0]                     wb_valid_i,
    input  logic [WB_WIDTH-1:0][$clog2(DEPTH)-1:0]  wb_rob_idx_i,
    input  rob_pkg::xlen_word_t [WB_WIDTH-1:0]      wb_value_i,

    // occupancy status
    output logic                                    full_o,
    output logic                                    empty_o,

    // oldest entry
    output logic                                    head_valid_o,
    output logic                                    head_ready_o,
    output rob_pkg::commit_entry_t                  head_entry_o
);

    import rob_pkg::*;

    localparam int unsigned IDX_W = $clog2(DEPTH);
    // one extra bit so that DEPTH itself fits
    localparam int unsigned CNT_W = IDX_W + 1;

    // per-entry control bits
    logic [DEPTH-1:0] valid_q;
    logic [DEPTH-1:0] ready_q;

    // per-entry payload
    disp_entry_t      fields_q [DEPTH];
    xlen_word_t       value_q  [DEPTH];

    // live entries
    logic [CNT_W-1:0] count_q;

    // squash walk results
    logic [DEPTH-1:0] squash_mask;
    logic [CNT_W-1:0] squash_cnt;
    logic [IDX_W-1:0] walk_idx;
    logic             walking;

    // ==================================================================
    // status and head read port
    // ==================================================================

    assign full_o  = (count_q == CNT_W'(DEPTH));
    assign empty_o = (count_q == '0);

    assign head_valid_o       = valid_q[head_idx_i];
    assign head_ready_o       = ready_q[head_idx_i];
    assign head_entry_o.disp  = fields_q[head_idx_i];
    assign head_entry_o.value = value_q[head_idx_i];

    // ==================================================================
    // squash mask
    // ==================================================================

    // walk from one past the branch towards the tail
    // every valid entry passed on the way is younger and gets dropped
    always_comb begin
        squash_mask = '0;
        squash_cnt  = '0;
        walking     = mispredict_i;
        walk_idx    = mispredict_rob_idx_i;
        for (int j = 1; j < DEPTH; j++) begin
            walk_idx = mispredict_rob_idx_i + IDX_W'(j);
            // reaching the tail ends the walk
            if (walk_idx == tail_idx_i) begin
                walking = 1'b0;
            end
            if (walking && valid_q[walk_idx]) begin
                squash_mask[walk_idx] = 1'b1;
                squash_cnt            = squash_cnt + CNT_W'(1);
            end
        end
    end

    // ==================================================================
    // control state
    // ==================================================================

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            valid_q <= '0;
            ready_q <= '0;
            count_q <= '0;
        end else begin
            // alloc and retire are already low in a squash cycle
            count_q <= count_q + CNT_W'(alloc_en_i) - CNT_W'(retire_en_i) - squash_cnt;

            // younger entries on a mispredict
            valid_q <= valid_q & ~squash_mask;

            // oldest entry leaves
            if (retire_en_i) begin
                valid_q[head_idx_i] <= 1'b0;
            end

            // new entry starts not ready
            if (alloc_en_i) begin
                valid_q[tail_idx_i] <= 1'b1;
                ready_q[tail_idx_i] <= 1'b0;
            end

            // results land only on live entries
            // writeback keeps running during a squash
            for (int w = 0; w < WB_WIDTH; w++) begin
                if (wb_valid_i[w] && valid_q[wb_rob_idx_i[w]]) begin
                    ready_q[wb_rob_idx_i[w]] <= 1'b1;
                end
            end
        end
    end

    // ==================================================================
    // payload storage
    // ==================================================================

    always_ff @(posedge clock) begin
        if (alloc_en_i) begin
            fields_q[tail_idx_i] <= disp_entry_i;
        end
        for (int w = 0; w < WB_WIDTH; w++) begin
            if (wb_valid_i[w] && valid_q[wb_rob_idx_i[w]]) begin
                value_q[wb_rob_idx_i[w]] <= wb_value_i[w];
            end
        end
    end

endmodule

//--- rob/rob_top.sv
// reorder buffer top level, connects allocation, retire
// and the entry table to the core-side ports
`timescale 1ns/1ps

module rob_top #(
    parameter int unsigned DEPTH    = 16,
    parameter int unsigned WB_WIDTH = 2
) (
    input  logic                                    clock,
    input  logic                                    reset,

    // dispatch
    input  logic                                    disp_valid_i,
    input  rob_pkg::disp_entry_t                    disp_entry_i,
    output logic                                    disp_ready_o,
    output logic                                    disp_alloc_o,
    output logic [$clog2(DEPTH)-1:0]                disp_rob_idx_o,

    // writeback
    input  logic [WB_WIDTH-1:0]                     wb_valid_i,
    input  logic [WB_WIDTH-1:0][$clog2(DEPTH)-1:0]  wb_rob_idx_i,
    input  rob_pkg::xlen_word_t [WB_WIDTH-1:0]      wb_value_i,

    // branch recovery
    input  logic                                    mispredict_i,
    input  logic [$clog2(DEPTH)-1:0]                mispredict_rob_idx_i,

    // commit
    output logic                                    commit_valid_o,
    output rob_pkg::commit_entry_t                  commit_entry_o
);

    import rob_pkg::*;

    localparam int unsigned IDX_W = $clog2(DEPTH);

    // table status
    logic             full;
    logic             empty;
    logic             head_valid;
    logic             head_ready;
    commit_entry_t    head_entry;

    // pointer side decisions
    logic             alloc_en;
    logic [IDX_W-1:0] tail_idx;
    logic             retire_en;
    logic [IDX_W-1:0] head_idx;

    // ==================================================================
    // allocation and retire, side by side
    // ==================================================================

    rob_alloc #(
        .DEPTH(DEPTH)
    ) u_alloc (
        .clock               (clock),
        .reset               (reset),
        .disp_valid_i        (disp_valid_i),
        .full_i              (full),
        .mispredict_i        (mispredict_i),
        .mispredict_rob_idx_i(mispredict_rob_idx_i),
        .alloc_en_o          (alloc_en),
        .tail_idx_o          (tail_idx),
        .disp_ready_o        (disp_ready_o)
    );

    rob_retire #(
        .DEPTH(DEPTH)
    ) u_retire (
        .clock         (clock),
        .reset         (reset),
        .empty_i       (empty),
        .head_valid_i  (head_valid),
        .head_ready_i  (head_ready),
        .head_entry_i  (head_entry),
        .mispredict_i  (mispredict_i),
        .retire_en_o   (retire_en),
        .head_idx_o    (head_idx),
        .commit_valid_o(commit_valid_o),
        .commit_entry_o(commit_entry_o)
    );

    // ==================================================================
    // entry storage
    // ==================================================================

    rob_entry_table #(
        .DEPTH   (DEPTH),
        .WB_WIDTH(WB_WIDTH)
    ) u_table (
        .clock               (clock),
        .reset               (reset),
        .mispredict_i        (mispredict_i),
        .mispredict_rob_idx_i(mispredict_rob_idx_i),
        .alloc_en_i          (alloc_en),
        .tail_idx_i          (tail_idx),
        .disp_entry_i        (disp_entry_i),
        .retire_en_i         (retire_en),
        .head_idx_i          (head_idx),
        .wb_valid_i          (wb_valid_i),
        .wb_rob_idx_i        (wb_rob_idx_i),
        .wb_value_i          (wb_value_i),
        .full_o              (full),
        .empty_o             (empty),
        .head_valid_o        (head_valid),
        .head_ready_o        (head_ready),
        .head_entry_o        (head_entry)
    );

    // dispatcher sees the allocation decision and slot directly
    assign disp_alloc_o   = alloc_en;
    assign disp_rob_idx_o = tail_idx;

endmodule

//--- testbench/tb_rob.sv
// reorder buffer testbench with clock, reset, file-driven stimulus
// and an in-order commit checker
`timescale 1ns/1ps

module tb_rob;

    import rob_pkg::*;

    localparam int unsigned DEPTH    = 16;
    localparam int unsigned WB_WIDTH = 2;
    localparam int unsigned IDX_W    = $clog2(DEPTH);
    // longest wait for the expected commits to drain
    localparam int DRAIN_LIMIT       = 200;

    logic                                 clock;
    logic                                 reset;
    logic                                 disp_valid_i;
    disp_entry_t                          disp_entry_i;
    logic                                 disp_ready_o;
    logic                                 disp_alloc_o;
    logic [IDX_W-1:0]                     disp_rob_idx_o;
    logic [WB_WIDTH-1:0]                  wb_valid_i;
    logic [WB_WIDTH-1:0][IDX_W-1:0]       wb_rob_idx_i;
    xlen_word_t [WB_WIDTH-1:0]            wb_value_i;
    logic                                 mispredict_i;
    logic [IDX_W-1:0]                     mispredict_rob_idx_i;
    logic                                 commit_valid_o;
    commit_entry_t                        commit_entry_o;

    // commits still owed by the DUT in program order
    commit_entry_t expect_q [$];

    // stimulus file state
    int          fd;
    int          line_no;
    int          commit_count;
    logic [31:0] fld [6];

    rob_top #(
        .DEPTH   (DEPTH),
        .WB_WIDTH(WB_WIDTH)
    ) uut (
        .clock               (clock),
        .reset               (reset),
        .disp_valid_i        (disp_valid_i),
        .disp_entry_i        (disp_entry_i),
        .disp_ready_o        (disp_ready_o),
        .disp_alloc_o        (disp_alloc_o),
        .disp_rob_idx_o      (disp_rob_idx_o),
        .wb_valid_i          (wb_valid_i),
        .wb_rob_idx_i        (wb_rob_idx_i),
        .wb_value_i          (wb_value_i),
        .mispredict_i        (mispredict_i),
        .mispredict_rob_idx_i(mispredict_rob_idx_i),
        .commit_valid_o      (commit_valid_o),
        .commit_entry_o      (commit_entry_o)
    );

    // 4 ns period
    initial clock = 1'b0;
    always #2 clock = ~clock;

    // ==================================================================
    // helpers
    // ==================================================================

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("SIMULATION FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("Error: %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic clear_inputs();
        disp_valid_i         = 1'b0;
        disp_entry_i         = '0;
        wb_valid_i           = '0;
        wb_rob_idx_i         = '0;
        wb_value_i           = '0;
        mispredict_i         = 1'b0;
        mispredict_rob_idx_i = '0;
    endtask

    // inputs change on the falling edge only
    task automatic start_cycle();
        @(negedge clock);
        clear_inputs();
    endtask

    task automatic read_fields(input int count, input string what);
        int got;
        got = 0;
        for (int i = 0; i < count; i++) begin
            got += $fscanf(fd, "%h", fld[i]);
        end
        if (got != count) begin
            abort_run($sformatf("line %0d: the %s command has too few fields", line_no, what));
        end
    endtask

    // rest of a comment line
    task automatic skip_line();
        int ch;
        ch = $fgetc(fd);
        while (ch != 10 && ch != -1) begin
            ch = $fgetc(fd);
        end
    endtask

    // wait until every expected commit was seen
    task automatic drain_commits();
        int waited;
        waited = 0;
        while (expect_q.size() != 0 && waited < DRAIN_LIMIT) begin
            start_cycle();
            #1;
            waited++;
        end
        if (expect_q.size() != 0) begin
            abort_run($sformatf("line %0d: %0d commits missing after %0d cycles",
                                line_no, expect_q.size(), DRAIN_LIMIT));
        end
    endtask

    // ==================================================================
    // one command per stimulus line
    // ==================================================================

    task automatic run_command(input logic [7:0] op);
        commit_entry_t exp_entry;
        case (op)
            "D": begin
                read_fields(6, "dispatch");
                start_cycle();
                disp_valid_i         = 1'b1;
                disp_entry_i.rd_wen  = fld[0][0];
                disp_entry_i.rd_arch = arch_reg_t'(fld[1]);
                disp_entry_i.new_prf = phys_reg_t'(fld[2]);
                disp_entry_i.old_prf = phys_reg_t'(fld[3]);
                #1;
                // ready and alloc agree while no mispredict is present
                check_value($sformatf("line %0d dispatch ready", line_no),
                            64'(fld[4][0]), 64'(disp_ready_o));
                check_value($sformatf("line %0d dispatch alloc", line_no),
                            64'(fld[4][0]), 64'(disp_alloc_o));
                check_value($sformatf("line %0d dispatch rob index", line_no),
                            64'(fld[5]), 64'(disp_rob_idx_o));
            end
            "W": begin
                read_fields(6, "writeback");
                start_cycle();
                wb_valid_i[0]   = fld[0][0];
                wb_rob_idx_i[0] = IDX_W'(fld[1]);
                wb_value_i[0]   = fld[2];
                wb_valid_i[1]   = fld[3][0];
                wb_rob_idx_i[1] = IDX_W'(fld[4]);
                wb_value_i[1]   = fld[5];
                #1;
            end
            "M": begin
                read_fields(1, "mispredict");
                start_cycle();
                mispredict_i         = 1'b1;
                mispredict_rob_idx_i = IDX_W'(fld[0]);
                #1;
            end
            "C": begin
                read_fields(5, "expect-commit");
                start_cycle();
                #1;
                exp_entry.disp.rd_wen  = fld[0][0];
                exp_entry.disp.rd_arch = arch_reg_t'(fld[1]);
                exp_entry.disp.new_prf = phys_reg_t'(fld[2]);
                exp_entry.disp.old_prf = phys_reg_t'(fld[3]);
                exp_entry.value        = fld[4];
                expect_q.push_back(exp_entry);
            end
            "I": begin
                start_cycle();
                #1;
            end
            "S": begin
                drain_commits();
            end
            "#": begin
                skip_line();
            end
            default: begin
                abort_run($sformatf("line %0d: unknown command %c", line_no, op));
            end
        endcase
    endtask

    // ==================================================================
    // commit monitor
    // ==================================================================

    // commit outputs are registered, so the falling edge sees them settled
    always @(negedge clock) begin : commit_monitor
        commit_entry_t expected;
        if (!reset && commit_valid_o !== 1'b0) begin
            if (commit_valid_o !== 1'b1) begin
                abort_run("commit_valid_o is neither high nor low after reset");
            end else if (expect_q.size() == 0) begin
                abort_run($sformatf("an unexpected commit of %h appeared", commit_entry_o));
            end else begin
                expected = expect_q.pop_front();
                commit_count++;
                check_value($sformatf("commit %0d", commit_count),
                            64'(expected), 64'(commit_entry_o));
            end
        end
    end

    // ==================================================================
    // main sequence
    // ==================================================================

    initial begin
        logic [7:0] op;
        int         code;
        logic       done;
        clear_inputs();
        reset        = 1'b1;
        line_no      = 0;
        commit_count = 0;
        done         = 1'b0;
        fd = $fopen("testbench/rob_stimulus.txt", "r");
        if (fd == 0) begin
            abort_run("the stimulus file testbench/rob_stimulus.txt could not be opened");
        end else begin
            // three rising edges in reset
            repeat (3) @(negedge clock);
            reset = 1'b0;
            while (!done) begin
                code = $fscanf(fd, " %c", op);
                if (code != 1) begin
                    done = 1'b1;
                end else begin
                    line_no++;
                    run_command(op);
                end
            end
            $fclose(fd);
            if (expect_q.size() != 0) begin
                abort_run($sformatf("%0d expected commits never arrived", expect_q.size()));
            end else begin
                $display("SIMULATION PASSED");
                $finish;
            end
        end
    end

endmodule

//--- testbench/rob_stimulus.txt
# D wen arch new old exp_alloc exp_idx | C wen arch new old value | M idx | I idle | S drain
# W v0 idx0 val0 v1 idx1 val1 (hex fields, one command per cycle)
I
I
# out of order writeback, both ports in one cycle
C 1 01 21 05 00000011
C 1 02 22 06 00000022
C 0 03 23 07 00000033
D 1 01 21 05 1 0
D 1 02 22 06 1 1
D 0 03 23 07 1 2
W 1 2 00000033 0 0 00000000
W 1 0 00000011 1 1 00000022
S
# fill all 16 entries, tail wraps past 15
D 1 04 24 08 1 3
D 1 05 25 09 1 4
D 1 06 26 0a 1 5
D 1 07 27 0b 1 6
D 1 08 28 0c 1 7
D 1 09 29 0d 1 8
D 1 0a 2a 0e 1 9
D 1 0b 2b 0f 1 a
D 1 0c 2c 10 1 b
D 1 0d 2d 11 1 c
D 1 0e 2e 12 1 d
D 1 0f 2f 13 1 e
D 1 10 30 14 1 f
D 1 11 31 15 1 0
D 1 12 32 16 1 1
D 1 13 33 17 1 2
# full, the 17th request waits for the head to retire
D 1 14 34 18 0 3
C 1 04 24 08 00000103
W 1 3 00000103 1 7 0000dead
D 1 14 34 18 0 3
D 1 14 34 18 1 3
# squash everything younger than entry 5, entry 7 was already written back
M 5
C 1 05 25 09 00000104
C 1 06 26 0a 00000105
C 0 1f 3f 00 00000106
D 0 1f 3f 00 1 6
W 1 6 00000106 1 5 00000105
W 1 4 00000104 1 7 0000beef
S
I
I
I
I

//--- verilog.f
common/rob_pkg.sv
rob/rob_alloc.sv
rob/rob_retire.sv
rob/rob_entry_table.sv
rob/rob_top.sv
testbench/tb_rob.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the reorder buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -j 0 \
    --top-module tb_rob -Mdir obj_dir -f verilog.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_rob > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "SIMULATION PASSED" "$LOG"; then
    exit 0
else
    echo "pass message not found in $LOG"
    exit 1
fi
